// File: include/rvcore_defines.svh
`ifndef RVCORE_DEFINES_SVH
`define RVCORE_DEFINES_SVH

// Machine word and address width
`define RVCORE_XLEN 32

// Architectural integer registers, x0 included
`define RVCORE_NREGS 32

// Address of the first fetch after reset
`define RVCORE_RESET_PC 32'h0000_0000

// State encoding the core parks in on an illegal instruction
`define RVCORE_HALT_CODE 4'hf

`endif

// File: verilog/rvcorePkg.sv
`include "rvcore_defines.svh"

package rvcorePkg;

    // One state per register transfer step
    typedef enum logic [3:0] {
        IF,
        ID,
        EX_R,
        EX_IALU,
        WB_ALU,
        EX_LDSD,
        MEM_LD,
        WB_LD,
        MEM_SD,
        EX_JAL,
        EX_JALR,
        ID_B,
        EX_B1,
        EX_B2,
        HALT = `RVCORE_HALT_CODE
    } cpuState;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011
    } opcode;

    // Operation class from the control decoder
    typedef enum logic [1:0] {
        ALUOP_ADD     = 2'b00,
        ALUOP_COMPARE = 2'b01,
        ALUOP_FUNCT   = 2'b10
    } aluOp;

    typedef enum logic [2:0] {
        FUNC_ADD,
        FUNC_SUB,
        FUNC_AND,
        FUNC_OR,
        FUNC_XOR,
        FUNC_SLT
    } aluFunc;

endpackage

// File: verilog/controlFsm.sv
module controlFsm (
    input  logic               clk,
    input  logic               reset,
    input  logic [6:0]         instrOpcode,
    input  logic [2:0]         instrFunct3,
    input  logic               wbAck,
    output rvcorePkg::cpuState state,
    output logic               halted
);
    import rvcorePkg::*;

    cpuState nextState;
    logic    aluFunct3Ok;

    // Shifts and SLTU are not implemented
    assign aluFunct3Ok = instrFunct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IF;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            IF: begin
                // Opcode comes straight off the bus on the acknowledge cycle
                if (wbAck) begin
                    if (instrOpcode == BRANCH && instrFunct3[2:1] == 2'b00) begin
                        nextState = ID_B;
                    end else begin
                        nextState = ID;
                    end
                end
            end
            ID: begin
                case (instrOpcode)
                    OP:          nextState = aluFunct3Ok ? EX_R : HALT;
                    OP_IMM:      nextState = aluFunct3Ok ? EX_IALU : HALT;
                    LOAD, STORE: nextState = (instrFunct3 == 3'b010) ? EX_LDSD : HALT;
                    JAL:         nextState = EX_JAL;
                    JALR:        nextState = (instrFunct3 == 3'b000) ? EX_JALR : HALT;
                    // Unsupported branches also end up here
                    default:     nextState = HALT;
                endcase
            end
            EX_R, EX_IALU: nextState = WB_ALU;
            EX_LDSD:       nextState = (instrOpcode == LOAD) ? MEM_LD : MEM_SD;
            MEM_LD:        nextState = wbAck ? WB_LD : MEM_LD;
            MEM_SD:        nextState = wbAck ? IF : MEM_SD;
            ID_B:          nextState = EX_B1;
            EX_B1:         nextState = EX_B2;
            WB_ALU, WB_LD, EX_JAL, EX_JALR, EX_B2: nextState = IF;
            HALT:          nextState = HALT;
            default:       nextState = HALT;
        endcase
    end

    assign halted = (state == HALT);

    // Encoding 14 is never reached
    stateDefined: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(state) && state inside {[IF:EX_B2], HALT});

endmodule

// File: verilog/stateToControl.sv
module stateToControl (
    input  rvcorePkg::cpuState state,
    output logic               pcWriteCond,
    output logic               pcWrite,
    output logic               iorD,
    output logic               memRead,
    output logic               memWrite,
    output logic               memToReg,
    output logic               irWrite,
    output logic               pcSource,
    output rvcorePkg::aluOp    aluOpSel,
    output logic [1:0]         aluSrcB,
    output logic               aluSrcA,
    output logic               regWrite
);
    import rvcorePkg::*;

    // aluSrcB: 00 register B, 01 constant 4, 10 immediate
    // aluSrcA: 0 instrPc, 1 register A
    always_comb begin
        pcWriteCond = 1'b0;
        pcWrite     = 1'b0;
        iorD        = 1'b0;
        memRead     = 1'b0;
        memWrite    = 1'b0;
        memToReg    = 1'b0;
        irWrite     = 1'b0;
        pcSource    = 1'b0;
        aluOpSel    = ALUOP_ADD;
        aluSrcB     = 2'b00;
        aluSrcA     = 1'b0;
        regWrite    = 1'b0;

        case (state)
            // IR <- MEM[PC], instrPc <- PC
            IF: begin
                memRead = 1'b1;
                irWrite = 1'b1;
            end
            // ALUOut <- instrPc + 4 while A and B load
            ID: aluSrcB = 2'b01;
            EX_R: begin
                aluSrcA  = 1'b1;
                aluOpSel = ALUOP_FUNCT;
            end
            EX_IALU: begin
                aluSrcA  = 1'b1;
                aluSrcB  = 2'b10;
                aluOpSel = ALUOP_FUNCT;
            end
            WB_ALU: begin
                regWrite = 1'b1;
                aluSrcB  = 2'b01;
                pcWrite  = 1'b1;
            end
            // Effective address
            EX_LDSD: begin
                aluSrcA = 1'b1;
                aluSrcB = 2'b10;
            end
            MEM_LD: begin
                iorD    = 1'b1;
                memRead = 1'b1;
            end
            WB_LD: begin
                memToReg = 1'b1;
                regWrite = 1'b1;
                aluSrcB  = 2'b01;
                pcWrite  = 1'b1;
            end
            // PC advances on the store acknowledge
            MEM_SD: begin
                iorD     = 1'b1;
                memWrite = 1'b1;
                aluSrcB  = 2'b01;
                pcWrite  = 1'b1;
            end
            // Link value was computed in ID
            EX_JAL: begin
                regWrite = 1'b1;
                aluSrcB  = 2'b10;
                pcWrite  = 1'b1;
            end
            EX_JALR: begin
                regWrite = 1'b1;
                aluSrcA  = 1'b1;
                aluSrcB  = 2'b10;
                pcWrite  = 1'b1;
            end
            ID_B: begin
                aluSrcB = 2'b01;
                pcWrite = 1'b1;
            end
            // Branch target into ALUOut
            EX_B1: aluSrcB = 2'b10;
            EX_B2: begin
                aluSrcA     = 1'b1;
                aluOpSel    = ALUOP_COMPARE;
                pcSource    = 1'b1;
                pcWriteCond = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        memExclusive: assert final (!(memRead && memWrite));
    end

endmodule

// File: verilog/aluDecoder.sv
module aluDecoder (
    input  rvcorePkg::aluOp   aluOpSel,
    input  logic [2:0]        funct3,
    input  logic              funct7b5,
    input  logic              isRegOp,
    output rvcorePkg::aluFunc func
);
    import rvcorePkg::*;

    always_comb begin
        case (aluOpSel)
            ALUOP_ADD:     func = FUNC_ADD;
            ALUOP_COMPARE: func = FUNC_SUB;
            default: begin
                case (funct3)
                    // Bit 30 of an immediate is not a subtract flag
                    3'b000:  func = (isRegOp && funct7b5) ? FUNC_SUB : FUNC_ADD;
                    3'b010:  func = FUNC_SLT;
                    3'b100:  func = FUNC_XOR;
                    3'b110:  func = FUNC_OR;
                    3'b111:  func = FUNC_AND;
                    default: func = FUNC_ADD;
                endcase
            end
        endcase
    end

endmodule

// File: verilog/alu.sv
`include "rvcore_defines.svh"

module alu (
    input  rvcorePkg::aluFunc       func,
    input  logic [`RVCORE_XLEN-1:0] a,
    input  logic [`RVCORE_XLEN-1:0] b,
    output logic [`RVCORE_XLEN-1:0] result,
    output logic                    zero
);
    import rvcorePkg::*;

    logic lessThan;

    // Signed compare for SLT and SLTI
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (func)
            FUNC_ADD: result = a + b;
            FUNC_SUB: result = a - b;
            FUNC_AND: result = a & b;
            FUNC_OR:  result = a | b;
            FUNC_XOR: result = a ^ b;
            FUNC_SLT: result = {{(`RVCORE_XLEN-1){1'b0}}, lessThan};
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: verilog/registerFile.sv
`include "rvcore_defines.svh"

module registerFile (
    input  logic                    clk,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [4:0]              rd,
    input  logic                    writeEnable,
    input  logic [`RVCORE_XLEN-1:0] writeData,
    output logic [`RVCORE_XLEN-1:0] readData1,
    output logic [`RVCORE_XLEN-1:0] readData2
);

    logic [`RVCORE_XLEN-1:0] regs [`RVCORE_NREGS];

    always_ff @(posedge clk) begin
        if (writeEnable && rd != 5'd0) begin
            regs[rd] <= writeData;
        end
    end

    // x0 is hardwired, its array slot is never written
    assign readData1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign readData2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: verilog/rvcoreDatapath.sv
`include "rvcore_defines.svh"

module rvcoreDatapath (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pcWriteCond,
    input  logic                    pcWrite,
    input  logic                    iorD,
    input  logic                    memRead,
    input  logic                    memWrite,
    input  logic                    memToReg,
    input  logic                    irWrite,
    input  logic                    pcSource,
    input  rvcorePkg::aluOp         aluOpSel,
    input  logic [1:0]              aluSrcB,
    input  logic                    aluSrcA,
    input  logic                    regWrite,
    output logic [6:0]              instrOpcode,
    output logic [2:0]              instrFunct3,
    output logic [`RVCORE_XLEN-1:0] wbAdr,
    output logic [`RVCORE_XLEN-1:0] wbWriteData,
    input  logic [`RVCORE_XLEN-1:0] wbReadData,
    output logic                    wbWe,
    output logic                    wbCyc,
    output logic                    wbStb,
    input  logic                    wbAck
);
    import rvcorePkg::*;

    logic [`RVCORE_XLEN-1:0] pc, instrPc, ir, regA, regB, aluOut, mdr;
    logic [`RVCORE_XLEN-1:0] rfData1, rfData2, imm, srcA, srcB, aluResult;
    aluFunc                  func;
    logic                    aluZero, memAccess, busGap, branchTaken, pcLoad;

    // Decode fields bypass IR while the fetch data is on the bus
    assign instrOpcode = irWrite ? wbReadData[6:0] : ir[6:0];
    assign instrFunct3 = irWrite ? wbReadData[14:12] : ir[14:12];

    always_comb begin
        case (ir[6:0])
            STORE:   imm = {{(`RVCORE_XLEN-12){ir[31]}}, ir[31:25], ir[11:7]};
            BRANCH:  imm = {{(`RVCORE_XLEN-12){ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
            JAL:     imm = {{(`RVCORE_XLEN-20){ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            default: imm = {{(`RVCORE_XLEN-12){ir[31]}}, ir[31:20]};
        endcase
    end

    assign srcA = aluSrcA ? regA : instrPc;

    always_comb begin
        case (aluSrcB)
            2'b00:   srcB = regB;
            2'b01:   srcB = `RVCORE_XLEN'd4;
            default: srcB = imm;
        endcase
    end

    registerFile registerFile_inst (
        .clk         (clk),
        .rs1         (ir[19:15]),
        .rs2         (ir[24:20]),
        .rd          (ir[11:7]),
        .writeEnable (regWrite),
        .writeData   (memToReg ? mdr : aluOut),
        .readData1   (rfData1),
        .readData2   (rfData2)
    );

    aluDecoder aluDecoder_inst (
        .aluOpSel (aluOpSel),
        .funct3   (ir[14:12]),
        .funct7b5 (ir[30]),
        .isRegOp  (ir[6:0] == OP),
        .func     (func)
    );

    alu alu_inst (
        .func   (func),
        .a      (srcA),
        .b      (srcB),
        .result (aluResult),
        .zero   (aluZero)
    );

    // funct3[0] set means BNE
    assign branchTaken = ir[12] ? !aluZero : aluZero;
    assign memAccess   = memRead || memWrite;
    // A memory state only commits its PC update on the acknowledge
    assign pcLoad = (pcWrite || (pcWriteCond && branchTaken)) && (!memAccess || wbAck);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= `RVCORE_RESET_PC;
            busGap <= 1'b0;
        end else begin
            if (pcLoad) begin
                pc <= pcSource ? aluOut : aluResult;
            end
            // One idle bus cycle after every acknowledge
            busGap <= wbAck;
        end
    end

    always_ff @(posedge clk) begin
        if (irWrite && wbAck) begin
            ir      <= wbReadData;
            instrPc <= pc;
        end
        if (memRead && iorD && wbAck) begin
            mdr <= wbReadData;
        end
        // ALUOut holds the address through wait states
        if (!memAccess) begin
            aluOut <= aluResult;
        end
        regA <= rfData1;
        regB <= rfData2;
    end

    // No request while reset holds the FSM in IF
    assign wbCyc       = memAccess && !busGap && !reset;
    assign wbStb       = memAccess && !busGap && !reset;
    assign wbWe        = memWrite;
    assign wbAdr       = iorD ? aluOut : pc;
    assign wbWriteData = regB;

    // A pending strobe keeps its cycle and address until the slave answers
    stbHeld: assert property (@(posedge clk) disable iff (reset)
        wbStb && !wbAck |=> wbStb && wbCyc && $stable(wbAdr) && $stable(wbWe));

endmodule

// File: verilog/rvcoreTop.sv
`include "rvcore_defines.svh"

module rvcoreTop (
    input  logic                    clk,
    input  logic                    reset,
    output logic [`RVCORE_XLEN-1:0] wbAdr,
    output logic [`RVCORE_XLEN-1:0] wbWriteData,
    input  logic [`RVCORE_XLEN-1:0] wbReadData,
    output logic                    wbWe,
    output logic                    wbCyc,
    output logic                    wbStb,
    input  logic                    wbAck,
    output logic                    halted
);
    import rvcorePkg::*;

    cpuState    state;
    aluOp       aluOpSel;
    logic [1:0] aluSrcB;
    logic [6:0] instrOpcode;
    logic [2:0] instrFunct3;
    logic       pcWriteCond, pcWrite, iorD, memRead, memWrite, memToReg;
    logic       irWrite, pcSource, aluSrcA, regWrite;

    controlFsm controlFsm_inst (
        .clk         (clk),
        .reset       (reset),
        .instrOpcode (instrOpcode),
        .instrFunct3 (instrFunct3),
        .wbAck       (wbAck),
        .state       (state),
        .halted      (halted)
    );

    stateToControl stateToControl_inst (
        .state       (state),
        .pcWriteCond (pcWriteCond),
        .pcWrite     (pcWrite),
        .iorD        (iorD),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .memToReg    (memToReg),
        .irWrite     (irWrite),
        .pcSource    (pcSource),
        .aluOpSel    (aluOpSel),
        .aluSrcB     (aluSrcB),
        .aluSrcA     (aluSrcA),
        .regWrite    (regWrite)
    );

    rvcoreDatapath rvcoreDatapath_inst (
        .clk         (clk),
        .reset       (reset),
        .pcWriteCond (pcWriteCond),
        .pcWrite     (pcWrite),
        .iorD        (iorD),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .memToReg    (memToReg),
        .irWrite     (irWrite),
        .pcSource    (pcSource),
        .aluOpSel    (aluOpSel),
        .aluSrcB     (aluSrcB),
        .aluSrcA     (aluSrcA),
        .regWrite    (regWrite),
        .instrOpcode (instrOpcode),
        .instrFunct3 (instrFunct3),
        .wbAdr       (wbAdr),
        .wbWriteData (wbWriteData),
        .wbReadData  (wbReadData),
        .wbWe        (wbWe),
        .wbCyc       (wbCyc),
        .wbStb       (wbStb),
        .wbAck       (wbAck)
    );

endmodule

// File: tests/rvcoreMemory.sv
module rvcoreMemory (
    input  logic        clk,
    input  logic        reset,
    input  logic [1:0]  waitCycles,
    input  logic [31:0] wbAdr,
    input  logic [31:0] wbWriteData,
    input  logic        wbWe,
    input  logic        wbCyc,
    input  logic        wbStb,
    output logic [31:0] wbReadData,
    output logic        wbAck
);
    timeunit 1ns;
    timeprecision 1ns;

    // 4 KB of words, upper address bits are ignored so the space wraps
    logic [31:0] mem [1024];
    logic [1:0]  waitLeft;
    logic [1:0]  remaining;
    logic        busy;

    // A new request takes its wait count from the testbench
    assign remaining = busy ? waitLeft : waitCycles;

    initial begin
        wbAck      = 1'b0;
        wbReadData = '0;
        busy       = 1'b0;
        waitLeft   = 2'd0;
    end

    always @(posedge clk) begin
        if (reset) begin
            wbAck <= 1'b0;
            busy  <= 1'b0;
        end else if (!(wbCyc && wbStb) || wbAck) begin
            // Ack lasts one cycle, an abandoned request is dropped
            wbAck <= 1'b0;
            busy  <= 1'b0;
        end else if (remaining == 2'd0) begin
            wbAck <= 1'b1;
            busy  <= 1'b0;
            if (wbWe) begin
                mem[wbAdr[11:2]] <= wbWriteData;
            end else begin
                wbReadData <= mem[wbAdr[11:2]];
            end
        end else begin
            busy     <= 1'b1;
            waitLeft <= remaining - 2'd1;
        end
    end

endmodule

// File: tests/rvcoreTb.sv
`include "rvcore_defines.svh"

module rvcoreTb;
    timeunit 1ns;
    timeprecision 1ns;

    import rvcorePkg::*;

    localparam int          progLen       = 48;
    localparam int          timeoutCycles = 2000;
    localparam int          maxSteps      = 200;
    localparam logic [31:0] illegalWord   = 32'hdead_b037;
    // ADD/SUB, SLT, XOR, OR, AND
    localparam logic [14:0] aluF3Set      = {3'b111, 3'b110, 3'b100, 3'b010, 3'b000};

    logic                    clk;
    logic                    reset;
    logic [`RVCORE_XLEN-1:0] wbAdr, wbWriteData, wbReadData;
    logic                    wbWe, wbCyc, wbStb, wbAck, halted;
    logic [1:0]              waitSel;

    logic [31:0]             lfsrState = 32'hbb025ee5;
    logic [31:0]             progImage [progLen + 2];
    logic [`RVCORE_XLEN-1:0] modelMem [1024];
    logic [`RVCORE_XLEN-1:0] modelRegs [`RVCORE_NREGS];
    int                      checks = 0;
    int                      mismatches = 0;
    int                      timeouts = 0;

    rvcoreTop rvcoreTop_inst (
        .clk         (clk),
        .reset       (reset),
        .wbAdr       (wbAdr),
        .wbWriteData (wbWriteData),
        .wbReadData  (wbReadData),
        .wbWe        (wbWe),
        .wbCyc       (wbCyc),
        .wbStb       (wbStb),
        .wbAck       (wbAck),
        .halted      (halted)
    );

    rvcoreMemory rvcoreMemory_inst (
        .clk         (clk),
        .reset       (reset),
        .waitCycles  (waitSel),
        .wbAdr       (wbAdr),
        .wbWriteData (wbWriteData),
        .wbWe        (wbWe),
        .wbCyc       (wbCyc),
        .wbStb       (wbStb),
        .wbReadData  (wbReadData),
        .wbAck       (wbAck)
    );

    always #20 clk = ~clk;

    // Fresh wait-state count every cycle
    always @(posedge clk) begin
        waitSel <= 2'(randomBits(2));
    end

    // Taps 32, 22, 2, 1
    function automatic logic lfsrStep();
        logic feedback;
        feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] randomBits(int count);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value = {value[30:0], lfsrStep()};
        end
        return value;
    endfunction

    function automatic logic [31:0] fillWord(int index);
        return (32'(index) + 32'h1357) * 32'h9e37_79b1;
    endfunction

    function automatic logic [31:0] encodeR(logic [2:0] f3, logic sub, logic [4:0] rd,
                                            logic [4:0] rs1, logic [4:0] rs2);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] encodeI(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
                                            logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encodeS(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] encodeB(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                            logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
    endfunction

    function automatic logic [31:0] encodeJ(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
    endfunction

    // Integer ALU behavior as the ISA defines it
    function automatic logic [`RVCORE_XLEN-1:0] aluResult(logic [2:0] f3, logic sub,
                                                         logic [`RVCORE_XLEN-1:0] a,
                                                         logic [`RVCORE_XLEN-1:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 1 : 0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return 'x;
        endcase
    endfunction

    function automatic void writeReg(logic [4:0] rd, logic [`RVCORE_XLEN-1:0] value);
        if (rd != 5'd0) begin
            modelRegs[rd] = value;
        end
    endfunction

    task automatic compareWord(string name, logic [`RVCORE_XLEN-1:0] expected,
                               logic [`RVCORE_XLEN-1:0] actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compareBit(string name, logic expected, logic actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Next completed bus transfer, sampled mid-cycle
    task automatic waitTransfer(
        output logic [`RVCORE_XLEN-1:0] adr,
        output logic                    we,
        output logic [`RVCORE_XLEN-1:0] writeData,
        output logic [`RVCORE_XLEN-1:0] readData,
        output bit                      ok
    );
        int cycles;
        ok = 1'b0;
        for (cycles = 0; cycles < timeoutCycles && !ok; cycles++) begin
            @(negedge clk);
            if (wbCyc && wbStb && wbAck) begin
                adr       = wbAdr;
                we        = wbWe;
                writeData = wbWriteData;
                readData  = wbReadData;
                ok        = 1'b1;
            end
        end
        if (!ok) begin
            $display("Timeout: no Wishbone acknowledge within %0d cycles", timeoutCycles);
            timeouts++;
        end
    endtask

    task automatic applyReset();
        int i;
        @(posedge clk);
        reset <= 1'b1;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            // The first reset edge is still ahead at i == 0
            if (i > 0) begin
                compareBit("wbCyc during reset", 1'b0, wbCyc);
                compareBit("wbStb during reset", 1'b0, wbStb);
                compareBit("wbWe during reset", 1'b0, wbWe);
                compareBit("halted during reset", 1'b0, halted);
            end
            @(posedge clk);
        end
        reset <= 1'b0;
        // The first fetch is on the bus in the cycle right after release
        @(negedge clk);
        compareBit("wbCyc after reset", 1'b1, wbCyc);
        compareBit("wbStb after reset", 1'b1, wbStb);
        compareBit("wbWe after reset", 1'b0, wbWe);
        compareWord("first fetch address", `RVCORE_RESET_PC, wbAdr);
    endtask

    task automatic buildProgram();
        int          idx;
        int          kind;
        int          target;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic        sub;
        logic [20:0] offset;
        // x1..x7 get defined values first
        for (idx = 0; idx < 7; idx++) begin
            progImage[idx] = encodeI(OP_IMM, 3'b000, 5'(idx + 1), 5'd0, 12'(randomBits(12)));
        end
        for (idx = 7; idx < progLen; idx++) begin
            kind   = int'(randomBits(4) % 10);
            rd     = 5'(randomBits(3));
            rs1    = 5'(randomBits(3));
            rs2    = 5'(randomBits(3));
            f3     = aluF3Set[int'(randomBits(3) % 5) * 3 +: 3];
            sub    = (f3 == 3'b000) && (randomBits(1) != 0);
            target = idx + 1 + int'(randomBits(6) % (progLen - idx));
            offset = 21'((target - idx) * 4);
            case (kind)
                0, 1: progImage[idx] = encodeR(f3, sub, rd, rs1, rs2);
                2, 3: progImage[idx] = encodeI(OP_IMM, f3, rd, rs1, 12'(randomBits(12)));
                // Offsets 0x800 up wrap through the 4 KB space into the data region
                4:    progImage[idx] = encodeI(LOAD, 3'b010, rd, 5'd0,
                                               12'h800 + 12'(randomBits(6) << 2));
                5, 6: progImage[idx] = encodeS(rs2, 5'd0, 12'h800 + 12'(randomBits(6) << 2));
                7:    progImage[idx] = encodeB(3'(randomBits(1)), rs1, rs2, offset[12:0]);
                8:    progImage[idx] = encodeJ(rd, offset);
                default: progImage[idx] = encodeI(JALR, 3'b000, rd, 5'd0, 12'(target * 4));
            endcase
        end
        progImage[progLen]     = encodeJ(5'd0, 21'd0);
        progImage[progLen + 1] = illegalWord;
    endtask

    task automatic loadImage(bit withIllegal);
        int i;
        for (i = 0; i < 1024; i++) begin
            modelMem[i] = fillWord(i);
        end
        for (i = 0; i < progLen + 2; i++) begin
            modelMem[i] = progImage[i];
        end
        if (withIllegal) begin
            modelMem[progLen] = illegalWord;
        end
        for (i = 0; i < 1024; i++) begin
            rvcoreMemory_inst.mem[i] = modelMem[i];
        end
    endtask

    task automatic watchHalt();
        int cycles;
        bit seen;
        seen = 1'b0;
        for (cycles = 0; cycles < timeoutCycles && !seen; cycles++) begin
            @(negedge clk);
            seen = (halted === 1'b1);
        end
        if (!seen) begin
            $display("Timeout: halted did not rise after the illegal instruction");
            timeouts++;
        end else begin
            for (cycles = 0; cycles < 20; cycles++) begin
                @(negedge clk);
                compareBit("wbCyc while halted", 1'b0, wbCyc);
                compareBit("wbStb while halted", 1'b0, wbStb);
                compareBit("halted held", 1'b1, halted);
            end
        end
    endtask

    task automatic runProgram(bit withIllegal);
        logic [`RVCORE_XLEN-1:0] pc, nextPc, instr, adr, wdata, rdata, memAddr, r1, r2;
        logic [`RVCORE_XLEN-1:0] immI, immS, immB, immJ;
        logic [4:0]              rd;
        logic [2:0]              f3;
        logic                    we;
        bit                      ok;
        bit                      done;
        int                      steps;
        int                      loopFetches;
        int                      i;

        loadImage(withIllegal);
        applyReset();
        for (i = 0; i < `RVCORE_NREGS; i++) begin
            modelRegs[i] = '0;
        end
        pc          = `RVCORE_RESET_PC;
        done        = 1'b0;
        loopFetches = 0;
        for (steps = 0; steps < maxSteps && !done; steps++) begin
            waitTransfer(adr, we, wdata, rdata, ok);
            if (!ok) begin
                return;
            end
            instr = modelMem[pc[11:2]];
            compareWord("fetch address", pc, adr);
            compareBit("fetch write enable", 1'b0, we);
            compareWord("fetch data", instr, rdata);
            compareBit("halted while running", 1'b0, halted);

            rd     = instr[11:7];
            f3     = instr[14:12];
            r1     = modelRegs[instr[19:15]];
            r2     = modelRegs[instr[24:20]];
            immI   = {{20{instr[31]}}, instr[31:20]};
            immS   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            immJ   = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            nextPc = pc + 4;
            case (instr[6:0])
                OP:     writeReg(rd, aluResult(f3, instr[30], r1, r2));
                OP_IMM: writeReg(rd, aluResult(f3, 1'b0, r1, immI));
                LOAD: begin
                    memAddr = r1 + immI;
                    waitTransfer(adr, we, wdata, rdata, ok);
                    if (!ok) begin
                        return;
                    end
                    compareWord("load address", memAddr, adr);
                    compareBit("load write enable", 1'b0, we);
                    compareWord("load data", modelMem[memAddr[11:2]], rdata);
                    writeReg(rd, modelMem[memAddr[11:2]]);
                end
                STORE: begin
                    memAddr = r1 + immS;
                    waitTransfer(adr, we, wdata, rdata, ok);
                    if (!ok) begin
                        return;
                    end
                    compareWord("store address", memAddr, adr);
                    compareBit("store write enable", 1'b1, we);
                    compareWord("store data", r2, wdata);
                    modelMem[memAddr[11:2]] = r2;
                end
                JAL: begin
                    writeReg(rd, pc + 4);
                    nextPc = pc + immJ;
                    if (nextPc == pc) begin
                        loopFetches++;
                        done = (loopFetches == 3);
                    end
                end
                JALR: begin
                    writeReg(rd, pc + 4);
                    nextPc = (r1 + immI) & ~32'd1;
                end
                BRANCH: begin
                    // funct3 bit 0 selects BNE
                    if (f3[0] ? (r1 != r2) : (r1 == r2)) begin
                        nextPc = pc + immB;
                    end
                end
                default: begin
                    watchHalt();
                    done = 1'b1;
                end
            endcase
            pc = nextPc;
        end
        if (!done) begin
            $display("Run ended after %0d instructions without reaching the loop or halt",
                     maxSteps);
            timeouts++;
        end
    endtask

    initial begin
        clk     = 1'b0;
        reset   = 1'b1;
        waitSel = 2'd0;
        buildProgram();
        runProgram(1'b0);
        // Same image with the self loop replaced by the illegal word
        runProgram(1'b1);
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: rvcore.f
+incdir+include
verilog/rvcorePkg.sv
verilog/controlFsm.sv
verilog/stateToControl.sv
verilog/aluDecoder.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/rvcoreDatapath.sv
verilog/rvcoreTop.sv
tests/rvcoreMemory.sv
tests/rvcoreTb.sv
